// ==== verilog/hit_monitor_pkg.sv ====
`default_nettype none

package hit_monitor_pkg;

	// front-end channel counts
	localparam int HIT_CHANNELS   = 8;
	localparam int BUSY_CHANNELS  = 2;

	// nominal pulse widths in clocks, a pulse of nominal or nominal+1 is good
	localparam int HIT_WIDTH_NOM  = 4;
	localparam int BUSY_WIDTH_NOM = 4;

	typedef logic [$clog2(HIT_CHANNELS)-1:0]  hit_sel_t;   // hit line index
	typedef logic [$clog2(BUSY_CHANNELS)-1:0] busy_sel_t;  // busy line index

	typedef logic [31:0] hit_cnt_t;    // hit event count
	typedef logic [15:0] busy_cnt_t;   // busy event count
	typedef logic [7:0]  err_cnt_t;    // saturating width error count
	typedef logic [15:0] trg_id_t;     // effective trigger count
	typedef logic [2:0]  width_cnt_t;  // running high-cycle count in the checker

endpackage

`default_nettype wire

// ==== verilog/edge_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module edge_select (
	input  logic                                      clk_in,
	input  logic                                      rst_in_N,
	input  logic [hit_monitor_pkg::HIT_CHANNELS-1:0]  hit_syn,       // synchronized hit lines
	input  logic [hit_monitor_pkg::BUSY_CHANNELS-1:0] busy_syn,      // synchronized busy lines
	input  logic                                      update_end,    // readout done level
	input  hit_monitor_pkg::hit_sel_t                 hit_fix_sel,   // static hit choice
	input  hit_monitor_pkg::busy_sel_t                busy_fix_sel,  // static busy choice
	output hit_monitor_pkg::hit_sel_t                 hit_sel,       // rotating hit choice
	output logic                                      fix_level,
	output logic                                      fix_rise,
	output logic                                      rot_level,
	output logic                                      rot_rise,
	output logic                                      busy_level,
	output logic                                      busy_rise
);

	import hit_monitor_pkg::*;

	logic [HIT_CHANNELS-1:0]  hit_d;         // previous sample of hit lines
	logic [BUSY_CHANNELS-1:0] busy_d;        // previous sample of busy lines
	logic                     update_end_d;  // previous sample of update_end
	logic [HIT_CHANNELS-1:0]  hit_rise_all;  // rise on every hit line
	logic [BUSY_CHANNELS-1:0] busy_rise_all; // rise on every busy line
	logic                     update_rise;   // leading edge of update_end

	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			hit_d        <= '0;
			busy_d       <= '0;
			update_end_d <= 1'b0;
		end else begin
			hit_d        <= hit_syn;
			busy_d       <= busy_syn;
			update_end_d <= update_end;
		end
	end

	assign hit_rise_all  = hit_syn & ~hit_d;        // high now, low last cycle
	assign busy_rise_all = busy_syn & ~busy_d;
	assign update_rise   = update_end & ~update_end_d;

	// next line is picked once the host has read the current counts
	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			hit_sel <= '0;
		end else if (update_rise) begin
			hit_sel <= hit_sel + 1'b1;  // wraps 7 to 0
		end
	end

	assign fix_level  = hit_syn[hit_fix_sel];
	assign fix_rise   = hit_rise_all[hit_fix_sel];
	assign rot_level  = hit_syn[hit_sel];
	assign rot_rise   = hit_rise_all[hit_sel];
	assign busy_level = busy_syn[busy_fix_sel];
	assign busy_rise  = busy_rise_all[busy_fix_sel];

	// selector moves only right after a readout edge
	a_sel_moves_on_update: assert property (
		@(posedge clk_in) disable iff (!rst_in_N)
		!$stable(hit_sel) |-> $past(update_rise)
	);

endmodule

`default_nettype wire

// ==== verilog/pulse_width_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module pulse_width_check #(
	parameter int NOMINAL = hit_monitor_pkg::HIT_WIDTH_NOM  // nominal width in clocks
) (
	input  logic clk_in,
	input  logic rst_in_N,
	input  logic level,       // monitored line
	input  logic rise,        // leading edge of the monitored line
	input  logic update_end,  // pulses overlapping readout are dropped
	output logic err_flag     // one clock per bad pulse
);

	import hit_monitor_pkg::*;

	logic       in_check;   // 0 idle, 1 measuring a pulse
	width_cnt_t width_cnt;  // high cycles seen since the rise cycle
	logic       too_short;  // fewer than nominal high cycles so far
	logic       over_max;   // more than nominal+1 high cycles

	// width_cnt+1 is the number of high cycles before the current one
	assign too_short = (width_cnt < width_cnt_t'(NOMINAL - 1));
	assign over_max  = (width_cnt > width_cnt_t'(NOMINAL));

	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			in_check  <= 1'b0;
			width_cnt <= '0;
			err_flag  <= 1'b0;
		end else if (!in_check) begin
			err_flag  <= 1'b0;                   // flag lasts a single clock
			width_cnt <= '0;
			in_check  <= rise && !update_end;    // start on a clean rise
		end else begin
			if (level) begin
				width_cnt <= width_cnt + 1'b1;
			end
			if (update_end) begin
				in_check <= 1'b0;                // abandon, no verdict
			end else if (!level) begin
				in_check <= 1'b0;                // pulse ended, judge its width
				err_flag <= too_short || over_max;
			end else if (over_max) begin
				in_check <= 1'b0;                // seventh high cycle, too long
				err_flag <= 1'b1;
			end
		end
	end

	// each verdict leaves check, so the flag cannot repeat
	a_err_one_cycle: assert property (
		@(posedge clk_in) disable iff (!rst_in_N)
		err_flag |=> !err_flag
	);

endmodule

`default_nettype wire

// ==== verilog/monitor_tally.sv ====
`timescale 1ns/1ns
`default_nettype none

module monitor_tally (
	input  logic                       clk_in,
	input  logic                       rst_in_N,
	input  logic                       update_end,    // clears all counts while high
	input  logic                       fix_rise,      // rise on the fixed hit line
	input  logic                       rot_rise,      // rise on the rotating hit line
	input  logic                       busy_rise,     // rise on the fixed busy line
	input  logic                       fix_err,       // width error on fixed hit line
	input  logic                       rot_err,       // width error on rotating hit line
	input  logic                       busy_err,      // width error on busy line
	output hit_monitor_pkg::hit_cnt_t  hit_cnt_fix,
	output hit_monitor_pkg::hit_cnt_t  hit_cnt_rot,
	output hit_monitor_pkg::busy_cnt_t busy_cnt,
	output hit_monitor_pkg::err_cnt_t  hit_err_cnt,
	output hit_monitor_pkg::err_cnt_t  busy_err_cnt
);

	import hit_monitor_pkg::*;

	logic hit_err_any;   // either hit checker flagged this cycle
	logic hit_err_full;  // hit error count at its ceiling
	logic busy_err_full; // busy error count at its ceiling

	assign hit_err_any   = fix_err || rot_err;  // coinciding flags count once
	assign hit_err_full  = (hit_err_cnt == '1);
	assign busy_err_full = (busy_err_cnt == '1);

	// event counters wrap
	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			hit_cnt_fix <= '0;
			hit_cnt_rot <= '0;
			busy_cnt    <= '0;
		end else if (update_end) begin
			hit_cnt_fix <= '0;                     // events during readout are lost
			hit_cnt_rot <= '0;
			busy_cnt    <= '0;
		end else begin
			if (fix_rise) begin
				hit_cnt_fix <= hit_cnt_fix + 1'b1;
			end
			if (rot_rise) begin
				hit_cnt_rot <= hit_cnt_rot + 1'b1;
			end
			if (busy_rise) begin
				busy_cnt <= busy_cnt + 1'b1;
			end
		end
	end

	// error counters stop at 255
	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			hit_err_cnt  <= '0;
			busy_err_cnt <= '0;
		end else if (update_end) begin
			hit_err_cnt  <= '0;
			busy_err_cnt <= '0;
		end else begin
			if (hit_err_any && !hit_err_full) begin
				hit_err_cnt <= hit_err_cnt + 1'b1;
			end
			if (busy_err && !busy_err_full) begin
				busy_err_cnt <= busy_err_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/trigger_id_tmr.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_id_tmr (
	input  logic                     clk_in,
	input  logic                     rst_in_N,
	input  logic                     eff_trg,  // one-cycle effective trigger strobe
	output hit_monitor_pkg::trg_id_t trg_id    // voted count, used as trigger id
);

	import hit_monitor_pkg::*;

	trg_id_t cnt_a;     // redundant copy a
	trg_id_t cnt_b;     // redundant copy b
	trg_id_t cnt_c;     // redundant copy c
	trg_id_t cnt_vote;  // bitwise 2 of 3 majority
	logic    mismatch;  // some copy disagrees

	assign cnt_vote = (cnt_a & cnt_b) | (cnt_a & cnt_c) | (cnt_b & cnt_c);
	assign mismatch = (cnt_a != cnt_b) || (cnt_a != cnt_c);

	// starts at all ones so the first trigger gets id 0
	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			cnt_a <= '1;
			cnt_b <= '1;
			cnt_c <= '1;
		end else if (eff_trg) begin
			cnt_a <= cnt_a + 1'b1;
			cnt_b <= cnt_b + 1'b1;
			cnt_c <= cnt_c + 1'b1;
		end else if (mismatch) begin
			cnt_a <= cnt_vote;  // scrub an upset copy
			cnt_b <= cnt_vote;
			cnt_c <= cnt_vote;
		end
	end

	always_ff @(posedge clk_in or negedge rst_in_N) begin
		if (!rst_in_N) begin
			trg_id <= '1;
		end else begin
			trg_id <= cnt_vote;  // output stage keeps the voter off the bus path
		end
	end

	// any quiet cycle repairs the copies
	a_copies_agree: assert property (
		@(posedge clk_in) disable iff (!rst_in_N)
		!eff_trg |=> (cnt_a == cnt_b) && (cnt_b == cnt_c)
	);

endmodule

`default_nettype wire

// ==== verilog/hit_trg_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module hit_trg_monitor (
	input  logic                                      clk_in,
	input  logic                                      rst_in_N,
	input  logic [hit_monitor_pkg::HIT_CHANNELS-1:0]  hit_syn,
	input  logic [hit_monitor_pkg::BUSY_CHANNELS-1:0] busy_syn,
	input  logic                                      update_end,
	input  logic                                      eff_trg,
	input  hit_monitor_pkg::hit_sel_t                 hit_fix_sel,
	input  hit_monitor_pkg::busy_sel_t                busy_fix_sel,
	output hit_monitor_pkg::hit_sel_t                 hit_sel,
	output hit_monitor_pkg::hit_cnt_t                 hit_cnt_fix,
	output hit_monitor_pkg::hit_cnt_t                 hit_cnt_rot,
	output hit_monitor_pkg::busy_cnt_t                busy_cnt,
	output hit_monitor_pkg::err_cnt_t                 hit_err_cnt,
	output hit_monitor_pkg::err_cnt_t                 busy_err_cnt,
	output hit_monitor_pkg::trg_id_t                  trg_id
);

	import hit_monitor_pkg::*;

	logic fix_level, fix_rise;    // fixed hit line
	logic rot_level, rot_rise;    // rotating hit line
	logic busy_level, busy_rise;  // fixed busy line
	logic fix_err, rot_err, busy_err;

	edge_select edge_sel (
		.clk_in, .rst_in_N, .hit_syn, .busy_syn, .update_end,
		.hit_fix_sel, .busy_fix_sel, .hit_sel,
		.fix_level, .fix_rise, .rot_level, .rot_rise, .busy_level, .busy_rise
	);

	pulse_width_check #(.NOMINAL(HIT_WIDTH_NOM)) fix_chk (
		.clk_in, .rst_in_N, .level(fix_level), .rise(fix_rise),
		.update_end, .err_flag(fix_err)
	);

	pulse_width_check #(.NOMINAL(HIT_WIDTH_NOM)) rot_chk (
		.clk_in, .rst_in_N, .level(rot_level), .rise(rot_rise),
		.update_end, .err_flag(rot_err)
	);

	pulse_width_check #(.NOMINAL(BUSY_WIDTH_NOM)) busy_chk (
		.clk_in, .rst_in_N, .level(busy_level), .rise(busy_rise),
		.update_end, .err_flag(busy_err)
	);

	monitor_tally tally (
		.clk_in, .rst_in_N, .update_end,
		.fix_rise, .rot_rise, .busy_rise, .fix_err, .rot_err, .busy_err,
		.hit_cnt_fix, .hit_cnt_rot, .busy_cnt, .hit_err_cnt, .busy_err_cnt
	);

	trigger_id_tmr trg_tmr (
		.clk_in, .rst_in_N, .eff_trg, .trg_id
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk_in,
	output logic rst_in_N
);

	initial begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;  // 100 ns period
	end

	initial begin
		rst_in_N = 1'b0;
		repeat (4) @(posedge clk_in);  // held through four rising edges
		#10 rst_in_N = 1'b1;           // released away from the edge
	end

endmodule

`default_nettype wire

// ==== dv/hit_trg_monitor_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module hit_trg_monitor_tb;

	import hit_monitor_pkg::*;

	logic clk_in, rst_in_N, update_end, eff_trg;
	logic [HIT_CHANNELS-1:0]  hit_syn;
	logic [BUSY_CHANNELS-1:0] busy_syn;
	hit_sel_t  hit_fix_sel, hit_sel, exp_sel;
	busy_sel_t busy_fix_sel;
	hit_cnt_t  hit_cnt_fix, hit_cnt_rot, exp_fix, exp_rot;
	busy_cnt_t busy_cnt, exp_busy;
	err_cnt_t  hit_err_cnt, busy_err_cnt, exp_hit_err, exp_busy_err;
	trg_id_t   trg_id, exp_trg;
	int        seed = 66;
	int        err_count = 0;
	int        timeout_count = 0;
	int        check_req_id = 0;   // bumped by stimulus to ask for a compare
	int        check_done_id = 0;  // echoed back by the compare process
	string     check_label;

	tb_clock_gen clk_gen (.clk_in, .rst_in_N);

	hit_trg_monitor dut (
		.clk_in, .rst_in_N, .hit_syn, .busy_syn, .update_end, .eff_trg,
		.hit_fix_sel, .busy_fix_sel, .hit_sel, .hit_cnt_fix, .hit_cnt_rot,
		.busy_cnt, .hit_err_cnt, .busy_err_cnt, .trg_id
	);

	// 1 when a pulse of width high cycles breaks the nominal..nominal+1 window
	function automatic int expected_width_err(input int width, input int nominal);
		return (width < nominal || width > nominal + 1) ? 1 : 0;
	endfunction

	function automatic err_cnt_t add_saturated(input err_cnt_t cnt, input int inc);
		return (inc != 0 && cnt != 8'hff) ? cnt + 1'b1 : cnt;  // stops at 255
	endfunction

	task automatic check_hit_cnt(input string what, input hit_cnt_t got, input hit_cnt_t exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s, %s is %0d, expected %0d", $time, check_label, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_busy_cnt(input string what, input busy_cnt_t got, input busy_cnt_t exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s, %s is %0d, expected %0d", $time, check_label, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_err_cnt(input string what, input err_cnt_t got, input err_cnt_t exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s, %s is %0d, expected %0d", $time, check_label, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_trg_id(input trg_id_t got, input trg_id_t exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s, trg_id is %h, expected %h", $time, check_label, got, exp);
			err_count++;
		end
	endtask

	task automatic check_sel(input hit_sel_t got, input hit_sel_t exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s, hit_sel is %0d, expected %0d", $time, check_label, got, exp);
			err_count++;
		end
	endtask

	// compare process, samples mid-cycle where outputs are settled
	always @(negedge clk_in) begin
		if (check_done_id != check_req_id) begin
			check_sel(hit_sel, exp_sel);
			check_hit_cnt("hit_cnt_fix", hit_cnt_fix, exp_fix);
			check_hit_cnt("hit_cnt_rot", hit_cnt_rot, exp_rot);
			check_busy_cnt("busy_cnt", busy_cnt, exp_busy);
			check_err_cnt("hit_err_cnt", hit_err_cnt, exp_hit_err);
			check_err_cnt("busy_err_cnt", busy_err_cnt, exp_busy_err);
			check_trg_id(trg_id, exp_trg);
			check_done_id = check_req_id;
		end
	end

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		timeout_count++;
	endtask

	task automatic drive_slot();  // next rising edge plus drive delay
		@(posedge clk_in);
		#10;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_slot();
	endtask

	task automatic request_check(input string label);
		int waited;
		waited = 0;
		check_label = label;
		check_req_id++;
		while (check_done_id != check_req_id) begin
			if (waited >= 5) begin
				report_timeout({"no compare done for ", label});
				break;
			end
			@(posedge clk_in);
			waited++;
		end
	endtask

	task automatic wait_for_reset();
		int waited;
		waited = 0;
		while (rst_in_N !== 1'b1) begin
			if (waited >= 10) begin
				report_timeout("reset was never released");
				break;
			end
			@(negedge clk_in);
			waited++;
		end
	endtask

	// equal-width pulses on both monitored hit lines flag in the same cycle
	task automatic send_pulse(input logic [HIT_CHANNELS-1:0] hmask,
			input logic [BUSY_CHANNELS-1:0] bmask, input int width);
		exp_fix  = exp_fix + hmask[hit_fix_sel];
		exp_rot  = exp_rot + hmask[exp_sel];
		exp_busy = exp_busy + bmask[busy_fix_sel];
		if (hmask[hit_fix_sel] || hmask[exp_sel]) begin
			exp_hit_err = add_saturated(exp_hit_err, expected_width_err(width, HIT_WIDTH_NOM));
		end
		if (bmask[busy_fix_sel]) begin
			exp_busy_err = add_saturated(exp_busy_err, expected_width_err(width, BUSY_WIDTH_NOM));
		end
		drive_slot();
		hit_syn  = hmask;
		busy_syn = bmask;
		idle(width);
		hit_syn  = '0;
		busy_syn = '0;
		idle(5);  // low gap before the next rise
	endtask

	task automatic send_triggers(input int k);
		repeat (k) begin
			drive_slot();
			eff_trg = 1'b1;
			exp_trg = exp_trg + 1'b1;
			drive_slot();
			eff_trg = 1'b0;
			idle($unsigned($random(seed)) % 3);  // uneven spacing
		end
	endtask

	task automatic pulse_update_end();
		int waited;
		waited = 0;
		drive_slot();
		update_end   = 1'b1;
		exp_sel      = exp_sel + 1'b1;  // wraps 7 to 0
		exp_fix      = '0;
		exp_rot      = '0;
		exp_busy     = '0;
		exp_hit_err  = '0;
		exp_busy_err = '0;
		while (hit_sel !== exp_sel) begin
			if (waited >= 4) begin
				report_timeout("hit_sel did not advance after update_end");
				break;
			end
			@(negedge clk_in);
			waited++;
		end
		drive_slot();
		update_end = 1'b0;
		idle(10);
	endtask

	initial begin
		logic [HIT_CHANNELS-1:0]  hmask;
		logic [BUSY_CHANNELS-1:0] bmask;
		int                       width;
		hit_syn      = '0;
		busy_syn     = '0;
		update_end   = 1'b0;
		eff_trg      = 1'b0;
		hit_fix_sel  = 3'd5;  // kept apart from the rotating line at start
		busy_fix_sel = 1'b1;
		{exp_sel, exp_fix, exp_rot, exp_busy, exp_hit_err, exp_busy_err} = '0;
		exp_trg      = '1;
		wait_for_reset();
		idle(2);
		request_check("after reset");
		repeat (2) begin
			send_triggers(1 + ($unsigned($random(seed)) % 40));
			idle(10);
			request_check("trigger id");
		end
		repeat (24) begin
			hmask = $random(seed);
			bmask = $random(seed);
			send_pulse(hmask, bmask, HIT_WIDTH_NOM + ($unsigned($random(seed)) % 2));
		end
		idle(10);
		request_check("good width pulses");
		for (width = 1; width <= 8; width++) begin
			hmask = '0;
			bmask = '0;
			hmask[hit_fix_sel]  = 1'b1;
			hmask[exp_sel]      = 1'b1;
			bmask[busy_fix_sel] = 1'b1;
			send_pulse(hmask, bmask, width);
		end
		idle(10);
		request_check("width sweep");
		repeat (8) begin
			send_pulse(8'hff, 2'b11, 2);  // leaves counts and errors to clear
			pulse_update_end();
			request_check("update_end clear");
		end
		$display("errors %0d, timeouts %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/hit_monitor_pkg.sv
verilog/edge_select.sv
verilog/pulse_width_check.sv
verilog/monitor_tally.sv
verilog/trigger_id_tmr.sv
verilog/hit_trg_monitor.sv
dv/tb_clock_gen.sv
dv/hit_trg_monitor_tb.sv
